/* Makefile */
SIM = obj_dir/hazardSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module hazardTb -o hazardSim

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

/* flist.f */
source/hazardPkg.sv
source/atDecoder.sv
source/stageTracker.sv
source/stallControl.sv
source/mduBusy.sv
source/hazardTop.sv
verif/hazardTop_props.sv
verif/hazardTb.sv

/* source/atDecoder.sv */
`default_nettype none

module atDecoder
	import hazardPkg::*;
(
	input  wire logic [31:0] instr,
	output tReg              a1,
	output tTime             tuse1,
	output tReg              a2,
	output tTime             tuse2,
	output tReg              a3,
	output tTime             tnew,
	output logic             mduReq,
	output logic             isMult
);

	// Instruction fields
	logic [5:0] opcode;
	logic [5:0] funct;
	tReg        rs;
	tReg        rt;
	tReg        rd;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	////////////////////////////////////////////////////////////////////////////
	// Lookup table
	// Row order is a1, tuse1, a2, tuse2, a3, tnew
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Unknown codes fall through as all zeros
		{a1, tuse1, a2, tuse2, a3, tnew} = '0;
		mduReq = 1'b0;
		isMult = 1'b0;
		case (opcode)
			OpR:
			begin
				case (funct)
					FnAddu: {a1, tuse1, a2, tuse2, a3, tnew} = {rs, 2'd1, rt, 2'd1, rd, 2'd2};
					FnSubu: {a1, tuse1, a2, tuse2, a3, tnew} = {rs, 2'd1, rt, 2'd1, rd, 2'd2};
					// Shift reads rt only
					FnSll:  {a1, tuse1, a2, tuse2, a3, tnew} = {5'd0, 2'd0, rt, 2'd1, rd, 2'd2};
					FnMult:
					begin
						{a1, tuse1, a2, tuse2, a3, tnew} = {rs, 2'd1, rt, 2'd1, 5'd0, 2'd0};
						mduReq = 1'b1;
						isMult = 1'b1;
					end
					// HI/LO moves land in rd
					FnMflo, FnMfhi:
					begin
						{a1, tuse1, a2, tuse2, a3, tnew} = {5'd0, 2'd0, 5'd0, 2'd0, rd, 2'd2};
						mduReq = 1'b1;
					end
					// Jump target needed right in decode
					FnJr:   {a1, tuse1, a2, tuse2, a3, tnew} = {rs, 2'd0, 5'd0, 2'd0, 5'd0, 2'd0};
					default: ;
				endcase
			end
			OpOri: {a1, tuse1, a2, tuse2, a3, tnew} = {rs, 2'd1, 5'd0, 2'd0, rt, 2'd2};
			OpLui: {a1, tuse1, a2, tuse2, a3, tnew} = {5'd0, 2'd0, 5'd0, 2'd0, rt, 2'd1};
			// Load data appears after memory
			OpLw:  {a1, tuse1, a2, tuse2, a3, tnew} = {rs, 2'd1, 5'd0, 2'd0, rt, 2'd3};
			// Store data only needed in memory stage
			OpSw:  {a1, tuse1, a2, tuse2, a3, tnew} = {rs, 2'd1, rt, 2'd2, 5'd0, 2'd0};
			OpBeq: {a1, tuse1, a2, tuse2, a3, tnew} = {rs, 2'd0, rt, 2'd0, 5'd0, 2'd0};
			OpJ:   {a1, tuse1, a2, tuse2, a3, tnew} = '0;
			OpJal: {a1, tuse1, a2, tuse2, a3, tnew} = {5'd0, 2'd0, 5'd0, 2'd0, RegRa, 2'd1};
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* source/hazardPkg.sv */
`default_nettype none

package hazardPkg;

	////////////////////////////////////////////////////////////////////////////
	// Basic types
	////////////////////////////////////////////////////////////////////////////

	// Register address, zero stands for no register
	typedef logic [4:0] tReg;

	// Tuse / Tnew in cycles
	typedef logic [1:0] tTime;

	// Forwarding source seen by the decode stage
	typedef enum logic [1:0]
	{
		fwdNone = 2'd0,
		fwdE    = 2'd1,
		fwdM    = 2'd2,
		fwdW    = 2'd3
	} tFwd;

	////////////////////////////////////////////////////////////////////////////
	// Opcode field, bits 31:26
	////////////////////////////////////////////////////////////////////////////

	localparam logic [5:0] OpR   = 6'h00;
	localparam logic [5:0] OpJ   = 6'h02;
	localparam logic [5:0] OpJal = 6'h03;
	localparam logic [5:0] OpBeq = 6'h04;
	localparam logic [5:0] OpOri = 6'h0d;
	localparam logic [5:0] OpLui = 6'h0f;
	localparam logic [5:0] OpLw  = 6'h23;
	localparam logic [5:0] OpSw  = 6'h2b;

	////////////////////////////////////////////////////////////////////////////
	// Function field for R type, bits 5:0
	////////////////////////////////////////////////////////////////////////////

	localparam logic [5:0] FnSll  = 6'h00;
	localparam logic [5:0] FnJr   = 6'h08;
	localparam logic [5:0] FnMfhi = 6'h10;
	localparam logic [5:0] FnMflo = 6'h12;
	localparam logic [5:0] FnMult = 6'h18;
	localparam logic [5:0] FnAddu = 6'h21;
	localparam logic [5:0] FnSubu = 6'h23;

	// Link register written by JAL
	localparam tReg RegRa = 5'd31;

	// Busy cycles of one multiply
	localparam int MduLatency = 5;
	// Counter width, wide enough to hold MduLatency
	localparam int MduCntWidth = $clog2(MduLatency + 1);

endpackage

`default_nettype wire

/* source/hazardTop.sv */
`default_nettype none

module hazardTop
	import hazardPkg::*;
(
	input  wire logic        clk,
	input  wire logic        rstN,
	input  wire logic [31:0] instr,
	input  wire logic        instrValid,
	output logic             instrReady,
	output tFwd              fwdSel1,
	output tFwd              fwdSel2,
	output logic             mduBusy
);

	// Decoded fields
	tReg  a1;
	tReg  a2;
	tReg  a3;
	tTime tuse1;
	tTime tuse2;
	tTime tnew;
	logic mduReq;
	logic isMult;

	// Tracked destinations
	tReg  aE;
	tReg  aM;
	tReg  aW;
	tTime tnewE;
	tTime tnewM;
	tTime tnewW;

	logic stall;
	logic accept;

	// Handshake, ready drops exactly on a stall
	assign instrReady = ~stall;
	assign accept     = instrValid & ~stall;

	atDecoder atDecoder_i (
		.instr  (instr),
		.a1     (a1),
		.tuse1  (tuse1),
		.a2     (a2),
		.tuse2  (tuse2),
		.a3     (a3),
		.tnew   (tnew),
		.mduReq (mduReq),
		.isMult (isMult)
	);

	stageTracker stageTracker_i (
		.clk    (clk),
		.rstN   (rstN),
		.accept (accept),
		.a3     (a3),
		.tnew   (tnew),
		.aE     (aE),
		.aM     (aM),
		.aW     (aW),
		.tnewE  (tnewE),
		.tnewM  (tnewM),
		.tnewW  (tnewW)
	);

	// Only an accepted MULT starts the counter
	mduBusy mduBusy_i (
		.clk       (clk),
		.rstN      (rstN),
		.startMult (accept & isMult),
		.busy      (mduBusy)
	);

	stallControl stallControl_i (
		.a1      (a1),
		.tuse1   (tuse1),
		.a2      (a2),
		.tuse2   (tuse2),
		.mduReq  (mduReq),
		.aE      (aE),
		.aM      (aM),
		.aW      (aW),
		.tnewE   (tnewE),
		.tnewM   (tnewM),
		.tnewW   (tnewW),
		.mduBusy (mduBusy),
		.stall   (stall),
		.fwdSel1 (fwdSel1),
		.fwdSel2 (fwdSel2)
	);

endmodule

`default_nettype wire

/* source/mduBusy.sv */
`default_nettype none

module mduBusy
	import hazardPkg::*;
(
	input  wire logic clk,
	input  wire logic rstN,
	input  wire logic startMult,
	output logic      busy
);

	// Remaining busy cycles
	logic [MduCntWidth-1:0] count;

	////////////////////////////////////////////////////////////////////////////
	// Down-counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			count <= '0;
		end
		else if (startMult)
		begin
			// Multiply enters execute
			count <= MduCntWidth'(MduLatency);
		end
		else if (count != '0)
		begin
			count <= count - 1'b1;
		end
	end

	// Nonzero count means unit occupied
	assign busy = (count != '0);

endmodule

`default_nettype wire

/* source/stageTracker.sv */
`default_nettype none

module stageTracker
	import hazardPkg::*;
(
	input  wire logic clk,
	input  wire logic rstN,
	input  wire logic accept,
	input  tReg       a3,
	input  tTime      tnew,
	output tReg       aE,
	output tReg       aM,
	output tReg       aW,
	output tTime      tnewE,
	output tTime      tnewM,
	output tTime      tnewW
);

	// One cycle closer to the result, stopping at zero
	function automatic tTime ageTime(input tTime t);
		ageTime = (t == 2'd0) ? 2'd0 : t - 2'd1;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Pipeline slots
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			// All stages hold bubbles
			aE    <= '0;
			aM    <= '0;
			aW    <= '0;
			tnewE <= '0;
			tnewM <= '0;
			tnewW <= '0;
		end
		else
		begin
			// Decode to execute also counts as one stage of aging
			if (accept)
			begin
				aE    <= a3;
				tnewE <= ageTime(tnew);
			end
			else
			begin
				aE    <= '0;
				tnewE <= '0;
			end

			// Execute to memory
			aM    <= aE;
			tnewM <= ageTime(tnewE);

			// Memory to writeback
			aW    <= aM;
			tnewW <= ageTime(tnewM);
		end
	end

endmodule

`default_nettype wire

/* source/stallControl.sv */
`default_nettype none

module stallControl
	import hazardPkg::*;
(
	input  tReg        a1,
	input  tTime       tuse1,
	input  tReg        a2,
	input  tTime       tuse2,
	input  wire logic  mduReq,
	input  tReg        aE,
	input  tReg        aM,
	input  tReg        aW,
	input  tTime       tnewE,
	input  tTime       tnewM,
	input  tTime       tnewW,
	input  wire logic  mduBusy,
	output logic       stall,
	output tFwd        fwdSel1,
	output tFwd        fwdSel2
);

	logic stall1;
	logic stall2;

	// Youngest matching stage wins; too late a result means stall
	function automatic void resolveSrc(input tReg a, input tTime tuse,
		output logic stl, output tFwd sel);
		stl = 1'b0;
		sel = fwdNone;
		// Register 0 is never a dependency
		if (a != '0)
		begin
			if (a == aE)
			begin
				sel = fwdE;
				stl = (tnewE > tuse);
			end
			else if (a == aM)
			begin
				sel = fwdM;
				stl = (tnewM > tuse);
			end
			else if (a == aW)
			begin
				sel = fwdW;
				stl = (tnewW > tuse);
			end
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Both sources plus the multiply unit
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		resolveSrc(a1, tuse1, stall1, fwdSel1);
		resolveSrc(a2, tuse2, stall2, fwdSel2);
		// MULT/MFLO/MFHI wait for a running multiply
		stall = stall1 | stall2 | (mduReq & mduBusy);
	end

endmodule

`default_nettype wire

/* verif/hazardTb.sv */
`default_nettype none

module hazardTb
	import hazardPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ResetCycles = 8;

	logic        clk = 1'b0;
	logic        rstN;
	logic [31:0] instr;
	logic        instrValid;
	logic        instrReady;
	tFwd         fwdSel1;
	tFwd         fwdSel2;
	logic        mduBusy;

	// One entry per cycle
	logic [31:0] qInstr[$];
	logic        qValid[$];
	logic        qReady[$];
	tFwd         qFwd1[$];
	tFwd         qFwd2[$];
	logic        qBusy[$];

	int cycles = 0;
	int cycleLimit;

	hazardTop hazardTop_i (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.instrReady (instrReady),
		.fwdSel1    (fwdSel1),
		.fwdSel2    (fwdSel2),
		.mduBusy    (mduBusy)
	);

	initial
	begin
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] rType(input tReg rs, input tReg rt, input tReg rd,
		input logic [5:0] fn);
		rType = {OpR, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input tReg rs, input tReg rt);
		iType = {op, rs, rt, 16'd0};
	endfunction

	task automatic addRow(input logic [31:0] in, input logic v, input logic rdy,
		input tFwd f1, input tFwd f2, input logic busy);
		qInstr.push_back(in);
		qValid.push_back(v);
		qReady.push_back(rdy);
		qFwd1.push_back(f1);
		qFwd2.push_back(f2);
		qBusy.push_back(busy);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic buildTable();
		// Idle right after reset
		addRow(32'd0, 1'b0, 1'b1, fwdNone, fwdNone, 1'b0);
		// ADDU chain with r1 read at distance 1, 2 and 3
		addRow(rType(5'd2, 5'd3, 5'd1, FnAddu), 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		addRow(rType(5'd1, 5'd0, 5'd4, FnAddu), 1'b1, 1'b1, fwdE, fwdNone, 1'b0);
		addRow(rType(5'd1, 5'd0, 5'd5, FnAddu), 1'b1, 1'b1, fwdM, fwdNone, 1'b0);
		addRow(rType(5'd1, 5'd4, 5'd6, FnAddu), 1'b1, 1'b1, fwdW, fwdM, 1'b0);
		// Load-use gets one bubble then forwards from M
		addRow(iType(OpLw, 5'd2, 5'd7), 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		addRow(rType(5'd7, 5'd0, 5'd8, FnAddu), 1'b1, 1'b0, fwdE, fwdNone, 1'b0);
		addRow(rType(5'd7, 5'd0, 5'd8, FnAddu), 1'b1, 1'b1, fwdM, fwdNone, 1'b0);
		// Store data has Tuse 2
		addRow(rType(5'd2, 5'd3, 5'd9, FnAddu), 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		addRow(iType(OpSw, 5'd0, 5'd9), 1'b1, 1'b1, fwdNone, fwdE, 1'b0);
		// Load in execute still early enough for store data
		addRow(iType(OpLw, 5'd2, 5'd11), 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		addRow(iType(OpSw, 5'd0, 5'd11), 1'b1, 1'b1, fwdNone, fwdE, 1'b0);
		// Zero destinations never match
		addRow({OpJ, 26'd0}, 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		addRow(iType(OpBeq, 5'd0, 5'd0), 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		addRow(rType(5'd0, 5'd0, 5'd10, FnAddu), 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		// MULT then MFLO held off for the busy window
		addRow(rType(5'd2, 5'd3, 5'd0, FnMult), 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		repeat (MduLatency)
			addRow(rType(5'd0, 5'd0, 5'd12, FnMflo), 1'b1, 1'b0, fwdNone, fwdNone, 1'b1);
		addRow(rType(5'd0, 5'd0, 5'd12, FnMflo), 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		// JAL result into r31 ready at once
		addRow({OpJal, 26'd0}, 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		addRow(rType(5'd31, 5'd0, 5'd0, FnJr), 1'b1, 1'b1, fwdE, fwdNone, 1'b0);
		// ADDU into r31 makes JR wait
		addRow(rType(5'd2, 5'd3, 5'd31, FnAddu), 1'b1, 1'b1, fwdNone, fwdNone, 1'b0);
		addRow(rType(5'd31, 5'd0, 5'd0, FnJr), 1'b1, 1'b0, fwdE, fwdNone, 1'b0);
		addRow(rType(5'd31, 5'd0, 5'd0, FnJr), 1'b1, 1'b1, fwdM, fwdNone, 1'b0);
		addRow(32'd0, 1'b0, 1'b1, fwdNone, fwdNone, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkBit(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal)
		begin
			$display("** Error at %0t: %s expected %0b, got %0b", $time, name, expVal, actVal);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic checkFwd(input string name, input tFwd expVal, input tFwd actVal);
		if (actVal !== expVal)
		begin
			$display("** Error at %0t: %s expected %s, got %s", $time, name,
				expVal.name(), actVal.name());
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Guard against a stuck run
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > cycleLimit)
		begin
			$display("TEST FAILED");
			$fatal(1, "Timeout, the run went past %0d clock cycles", cycleLimit);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		buildTable();
		cycleLimit = qInstr.size() + ResetCycles + 20;
		instr      = '0;
		instrValid = 1'b0;
		rstN       = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		for (int i = 0; i < qInstr.size(); i++)
		begin
			instr      = qInstr[i];
			instrValid = qValid[i];
			// Sample mid low phase once combinational outputs settle
			#5;
			checkBit($sformatf("instrReady row %0d", i), qReady[i], instrReady);
			checkFwd($sformatf("fwdSel1 row %0d", i), qFwd1[i], fwdSel1);
			checkFwd($sformatf("fwdSel2 row %0d", i), qFwd2[i], fwdSel2);
			checkBit($sformatf("mduBusy row %0d", i), qBusy[i], mduBusy);
			@(negedge clk);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/hazardTop_props.sv */
`default_nettype none

module hazardTop_props
	import hazardPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic instrReady,
	input wire logic mduBusy,
	input tFwd       fwdSel1,
	input tFwd       fwdSel2,
	input tReg       aE,
	input tReg       aM,
	input tReg       aW
);

	timeunit 1ns;
	timeprecision 1ps;

	logic       zeroSel1;
	logic       zeroSel2;
	logic [3:0] busyRun;

	// Selection pointing at a stage that writes nothing
	assign zeroSel1 = (fwdSel1 == fwdE && aE == '0) || (fwdSel1 == fwdM && aM == '0)
		|| (fwdSel1 == fwdW && aW == '0);
	assign zeroSel2 = (fwdSel2 == fwdE && aE == '0) || (fwdSel2 == fwdM && aM == '0)
		|| (fwdSel2 == fwdW && aW == '0);

	// Length of the current busy window
	always_ff @(posedge clk)
	begin
		if (!rstN)
			busyRun <= '0;
		else if (mduBusy)
			busyRun <= busyRun + 1'b1;
		else
			busyRun <= '0;
	end

	readyAfterReset: assert property (@(posedge clk) !rstN |=> instrReady)
		else $error("instrReady low in the cycle after reset");

	noZeroFwd1: assert property (@(posedge clk) disable iff (!rstN) !zeroSel1)
		else $error("fwdSel1 names a stage with destination 0");

	noZeroFwd2: assert property (@(posedge clk) disable iff (!rstN) !zeroSel2)
		else $error("fwdSel2 names a stage with destination 0");

	busyBounded: assert property (@(posedge clk) disable iff (!rstN) busyRun <= MduLatency)
		else $error("mduBusy held longer than the multiply latency");

endmodule

bind hazardTop hazardTop_props hazardTop_props_i (
	.clk        (clk),
	.rstN       (rstN),
	.instrReady (instrReady),
	.mduBusy    (mduBusy),
	.fwdSel1    (fwdSel1),
	.fwdSel2    (fwdSel2),
	.aE         (aE),
	.aM         (aM),
	.aW         (aW)
);

`default_nettype wire
